/* rtl/rx_mem_pkg.sv */
package rx_mem_pkg;

  // --------------------------------------------------
  // Buffer geometry
  // --------------------------------------------------

  // Word address width, 1024 words of packet storage
  localparam int RAM_ADDR_WIDTH = 10;
  localparam int RAM_DEPTH      = 1 << RAM_ADDR_WIDTH;

  localparam int RAM_WORD_BITS  = 64;
  localparam int WORD_BYTES     = RAM_WORD_BITS / 8;

  typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

  // --------------------------------------------------
  // Buffer word
  // --------------------------------------------------

  // Byte index 7 is the top byte, so big-endian byte n
  // lives at bytes[7 - n]
  typedef union packed {
    logic [RAM_WORD_BITS-1:0]   word;
    logic [WORD_BYTES-1:0][7:0] bytes;
  } ram_word_t;

endpackage

/* rtl/rx_access_pkg.sv */
package rx_access_pkg;

  // --------------------------------------------------
  // Access port address layout
  // --------------------------------------------------

  // Byte address is the word address followed by a byte offset
  localparam int BYTE_OFF_WIDTH    = 3;
  localparam int ACCESS_ADDR_WIDTH = rx_mem_pkg::RAM_ADDR_WIDTH + BYTE_OFF_WIDTH;

  typedef logic [BYTE_OFF_WIDTH-1:0] byte_off_t;

  // Read size codes, 4 to 7 are not accepted
  typedef enum logic [2:0] {
    SIZE_8  = 3'd0,
    SIZE_16 = 3'd1,
    SIZE_32 = 3'd2,
    SIZE_64 = 3'd3
  } access_size_e;

  // --------------------------------------------------
  // Controller states
  // --------------------------------------------------

  typedef enum logic [2:0] {
    IDLE            = 3'd0,
    LOAD            = 3'd1,
    READ_WAIT       = 3'd2,
    READ_LAST       = 3'd3,
    READ_FIRST_WAIT = 3'd4,
    READ_FIRST      = 3'd5,
    READ_SECOND     = 3'd6
  } ctrl_state_e;

endpackage

/* rtl/rx_read_if.sv */
`timescale 1ns/1ps

// Read sequencing between the controller and the extractor
interface rx_read_if;

  logic accept;
  logic next_word;
  logic capture_first;
  logic finish;
  // Request spans two RAM words, from the live request inputs
  logic two_words;

  modport ctrl (
    output accept,
    output next_word,
    output capture_first,
    output finish,
    input  two_words
  );

  modport extract (
    input  accept,
    input  next_word,
    input  capture_first,
    input  finish,
    output two_words
  );

endinterface

/* rtl/rx_buffer_ram.sv */
`timescale 1ns/1ps

module rx_buffer_ram (
  input  logic                  i_clk,
  input  logic                  i_wr_en,
  input  rx_mem_pkg::ram_addr_t i_wr_addr,
  input  rx_mem_pkg::ram_word_t i_wr_data,
  input  rx_mem_pkg::ram_addr_t i_rd_addr,
  output rx_mem_pkg::ram_word_t o_rd_data
);

  import rx_mem_pkg::*;

  ram_word_t mem [RAM_DEPTH];

  // Separate write and read ports, read data registered
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* rtl/rx_fifo_loader.sv */
`timescale 1ns/1ps

module rx_fifo_loader (
  input  logic                                 i_clk,
  input  logic                                 i_areset,
  input  logic                                 i_start,
  input  logic                                 i_fifo_empty,
  input  logic [rx_mem_pkg::RAM_WORD_BITS-1:0] i_fifo_data,
  output logic                                 o_fifo_rd_en,
  output logic                                 o_packet_read,
  output logic                                 o_done,
  output logic                                 o_wr_en,
  output rx_mem_pkg::ram_addr_t                o_wr_addr,
  output rx_mem_pkg::ram_word_t                o_wr_data
);

  import rx_mem_pkg::*;

  logic      active_q;
  ram_addr_t addr_q;
  logic      end_q;
  logic      pop;

  // FWFT FIFO, the head word is valid whenever it is not empty
  assign pop = active_q && !i_fifo_empty;

  assign o_fifo_rd_en   = pop;
  assign o_wr_en        = pop;
  assign o_wr_addr      = addr_q;
  assign o_wr_data.word = i_fifo_data;

  // Packet read pulse doubles as the done strobe to the controller
  assign o_packet_read = end_q;
  assign o_done        = end_q;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      active_q <= 1'b0;
      addr_q   <= '0;
      end_q    <= 1'b0;
    end else begin
      end_q <= 1'b0;
      if (i_start) begin
        // Every packet starts at word 0
        active_q <= 1'b1;
        addr_q   <= '0;
      end else if (pop) begin
        addr_q <= addr_q + ram_addr_t'(1);
      end else if (active_q) begin
        // FIFO drained, packet is complete
        active_q <= 1'b0;
        end_q    <= 1'b1;
      end
    end
  end

endmodule

/* rtl/rx_buffer_ctrl.sv */
`timescale 1ns/1ps

module rx_buffer_ctrl (
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  logic                        i_packet_available,
  input  logic                        i_fifo_empty,
  input  logic                        i_rd_en,
  input  rx_access_pkg::access_size_e i_wordsize,
  input  logic                        i_load_done,
  output logic                        o_load_start,
  output logic                        o_wait,
  output logic                        o_rd_dv,
  rx_read_if.ctrl                     rd
);

  import rx_access_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        wait_q;
  logic        rd_dv_q;
  logic        load_req;
  logic        accept;
  logic        finish;

  // --------------------------------------------------
  // Arbitration, a load wins over a read
  // --------------------------------------------------

  assign load_req = (state_q == IDLE) && i_packet_available && !i_fifo_empty;
  assign accept   = (state_q == IDLE) && !load_req && !wait_q && i_rd_en &&
                    (i_wordsize <= SIZE_64);
  assign finish   = (state_q == READ_LAST) || (state_q == READ_SECOND);

  assign o_load_start     = load_req;
  assign rd.accept        = accept;
  assign rd.next_word     = (state_q == READ_FIRST_WAIT);
  assign rd.capture_first = (state_q == READ_FIRST);
  assign rd.finish        = finish;

  assign o_wait  = wait_q;
  assign o_rd_dv = rd_dv_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (load_req) begin
          state_d = LOAD;
        end else if (accept) begin
          // Spanning reads need one more RAM word
          state_d = rd.two_words ? READ_FIRST_WAIT : READ_WAIT;
        end
      end
      LOAD:            state_d = i_load_done ? IDLE : LOAD;
      READ_WAIT:       state_d = READ_LAST;
      READ_FIRST_WAIT: state_d = READ_FIRST;
      READ_FIRST:      state_d = READ_SECOND;
      default:         state_d = IDLE;
    endcase
  end

  // --------------------------------------------------
  // State and access port flags
  // --------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= IDLE;
      wait_q  <= 1'b0;
      rd_dv_q <= 1'b0;
    end else begin
      state_q <= state_d;
      rd_dv_q <= finish;
      if (accept) begin
        wait_q <= 1'b1;
      end else if (finish) begin
        wait_q <= 1'b0;
      end
    end
  end

endmodule

/* rtl/rx_read_extract.sv */
`timescale 1ns/1ps

module rx_read_extract (
  input  logic                                        i_clk,
  input  logic                                        i_areset,
  input  logic [rx_access_pkg::ACCESS_ADDR_WIDTH-1:0] i_addr,
  input  rx_access_pkg::access_size_e                 i_wordsize,
  output rx_mem_pkg::ram_addr_t                       o_rd_addr,
  input  rx_mem_pkg::ram_word_t                       i_rd_data,
  output logic [rx_mem_pkg::RAM_WORD_BITS-1:0]        o_rd_data,
  rx_read_if.extract                                  rd
);

  import rx_mem_pkg::*;
  import rx_access_pkg::*;

  ram_addr_t                rd_addr_q;
  logic                     two_q;
  byte_off_t                off_q;
  access_size_e             size_q;
  ram_word_t                first_q;
  logic [4:0]               span_end;
  logic [3:0]               n_bytes;
  logic [RAM_WORD_BITS-1:0] result;

  // Spans two words when offset plus size runs past byte 8
  assign span_end     = 5'(i_addr[BYTE_OFF_WIDTH-1:0]) + 5'(4'd1 << i_wordsize);
  assign rd.two_words = (span_end > 5'd8);

  assign o_rd_addr = rd_addr_q;
  assign n_bytes   = 4'd1 << size_q;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      rd_addr_q <= '0;
      two_q     <= 1'b0;
    end else if (rd.accept) begin
      rd_addr_q <= i_addr[ACCESS_ADDR_WIDTH-1:BYTE_OFF_WIDTH];
      two_q     <= rd.two_words;
    end else if (rd.next_word) begin
      rd_addr_q <= rd_addr_q + ram_addr_t'(1);
    end
  end

  // --------------------------------------------------
  // Byte selection
  // --------------------------------------------------

  // Bytes 0..7 of the stream come from the first word, 8..15 from
  // the second; single-word reads only touch the first half
  always_comb begin
    ram_word_t  hi_word;
    logic [3:0] pos;
    int         slot;
    hi_word = two_q ? first_q : i_rd_data;
    result  = '0;
    for (int i = 0; i < WORD_BYTES; i++) begin
      pos  = 4'(off_q) + 4'(i);
      slot = int'(n_bytes) - 1 - i;
      if (slot >= 0) begin
        if (pos[3]) begin
          result[8*slot +: 8] = i_rd_data.bytes[3'd7 - pos[2:0]];
        end else begin
          result[8*slot +: 8] = hi_word.bytes[3'd7 - pos[2:0]];
        end
      end
    end
  end

  // Request details and result
  always_ff @(posedge i_clk) begin
    if (rd.accept) begin
      off_q  <= i_addr[BYTE_OFF_WIDTH-1:0];
      size_q <= i_wordsize;
    end
    if (rd.capture_first) begin
      first_q <= i_rd_data;
    end
    if (rd.finish) begin
      o_rd_data <= result;
    end
  end

endmodule

/* rtl/rx_buffer_top.sv */
`timescale 1ns/1ps

module rx_buffer_top (
  input  logic                                        i_clk,
  input  logic                                        i_areset,

  input  logic                                        i_dispatch_packet_available,
  output logic                                        o_dispatch_packet_read,
  input  logic                                        i_dispatch_fifo_empty,
  output logic                                        o_dispatch_fifo_rd_en,
  input  logic [rx_mem_pkg::RAM_WORD_BITS-1:0]        i_dispatch_fifo_rd_data,

  output logic                                        o_access_port_wait,
  input  logic [rx_access_pkg::ACCESS_ADDR_WIDTH-1:0] i_access_port_addr,
  input  logic [2:0]                                  i_access_port_wordsize,
  input  logic                                        i_access_port_rd_en,
  output logic                                        o_access_port_rd_dv,
  output logic [rx_mem_pkg::RAM_WORD_BITS-1:0]        o_access_port_rd_data
);

  import rx_mem_pkg::*;
  import rx_access_pkg::*;

  logic      load_start;
  logic      load_done;
  logic      wr_en;
  ram_addr_t wr_addr;
  ram_word_t wr_data;
  ram_addr_t rd_addr;
  ram_word_t rd_data;

  rx_read_if rd_if ();

  rx_buffer_ctrl ctrl_i (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_packet_available (i_dispatch_packet_available),
    .i_fifo_empty       (i_dispatch_fifo_empty),
    .i_rd_en            (i_access_port_rd_en),
    .i_wordsize         (access_size_e'(i_access_port_wordsize)),
    .i_load_done        (load_done),
    .o_load_start       (load_start),
    .o_wait             (o_access_port_wait),
    .o_rd_dv            (o_access_port_rd_dv),
    .rd                 (rd_if.ctrl)
  );

  rx_fifo_loader loader_i (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_start       (load_start),
    .i_fifo_empty  (i_dispatch_fifo_empty),
    .i_fifo_data   (i_dispatch_fifo_rd_data),
    .o_fifo_rd_en  (o_dispatch_fifo_rd_en),
    .o_packet_read (o_dispatch_packet_read),
    .o_done        (load_done),
    .o_wr_en       (wr_en),
    .o_wr_addr     (wr_addr),
    .o_wr_data     (wr_data)
  );

  rx_read_extract extract_i (
    .i_clk      (i_clk),
    .i_areset   (i_areset),
    .i_addr     (i_access_port_addr),
    .i_wordsize (access_size_e'(i_access_port_wordsize)),
    .o_rd_addr  (rd_addr),
    .i_rd_data  (rd_data),
    .o_rd_data  (o_access_port_rd_data),
    .rd         (rd_if.extract)
  );

  rx_buffer_ram ram_i (
    .i_clk     (i_clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

// 50 MHz clock with reset held for the first cycles
module tb_clkgen (
  output logic o_clk,
  output logic o_areset
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 5;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2;
    o_areset = 1'b0;
  end

endmodule

/* tb/rx_buffer_assert.sv */
`timescale 1ns/1ps

module rx_buffer_assert (
  input logic i_clk,
  input logic i_areset,
  input logic i_packet_read,
  input logic i_fifo_rd_en,
  input logic i_wait,
  input logic i_rd_dv
);

  // Data valid is a single pulse released together with wait
  rd_dv_single : assert property (@(posedge i_clk) disable iff (i_areset)
    i_rd_dv |=> !i_rd_dv)
    else $error("rd_dv stayed high for more than one cycle");

  rd_dv_with_wait : assert property (@(posedge i_clk) disable iff (i_areset)
    i_rd_dv |-> $fell(i_wait))
    else $error("rd_dv did not coincide with wait falling");

  // --------------------------------------------------
  // Load side
  // --------------------------------------------------

  no_pop_at_end : assert property (@(posedge i_clk) disable iff (i_areset)
    !(i_packet_read && i_fifo_rd_en))
    else $error("packet_read and fifo_rd_en high together");

  no_dv_in_load : assert property (@(posedge i_clk) disable iff (i_areset)
    (i_fifo_rd_en || i_packet_read) |-> !i_rd_dv)
    else $error("rd_dv high while a packet loads");

endmodule

bind rx_buffer_top rx_buffer_assert assert_i (
  .i_clk         (i_clk),
  .i_areset      (i_areset),
  .i_packet_read (o_dispatch_packet_read),
  .i_fifo_rd_en  (o_dispatch_fifo_rd_en),
  .i_wait        (o_access_port_wait),
  .i_rd_dv       (o_access_port_rd_dv)
);

/* tb/rx_buffer_tb.sv */
`timescale 1ns/1ps

module rx_buffer_tb;

  localparam int PKT_WORDS    = 40;
  localparam int SECOND_WORDS = 8;
  localparam int ACCEPT_LIMIT = 60;
  localparam int DV_LIMIT     = 8;
  localparam int BAD_CYCLES   = 6;
  localparam int MODE_READ    = 0;
  localparam int MODE_INVALID = 1;
  localparam int MODE_NEWPKT  = 2;

  logic        clk;
  logic        areset;
  logic        pkt_avail = 1'b0;
  logic        pkt_read;
  logic        fifo_empty;
  logic        fifo_rd_en;
  logic [63:0] fifo_rd_data;
  logic        acc_wait;
  logic [12:0] acc_addr = '0;
  logic [2:0]  acc_size = '0;
  logic        acc_rd_en = 1'b0;
  logic        acc_rd_dv;
  logic [63:0] acc_rd_data;

  // FWFT FIFO model and the packet image expected in the buffer
  logic [63:0] fifo_mem [0:63];
  logic [5:0]  rd_ptr = '0;
  logic [6:0]  fifo_len = '0;
  logic        pop_now = 1'b0;
  logic [63:0] ref_words [0:1023];

  integer seed = 32'h46b0086e;
  int     pop_count = 0;
  int     pr_count = 0;
  int     err_count = 0;
  int     cycle_count = 0;
  int     n_pass = 0;
  int     n_fail = 0;

  string       t_name [$];
  logic [12:0] t_addr [$];
  logic [2:0]  t_size [$];
  int          t_mode [$];

  tb_clkgen clkgen_i (
    .o_clk    (clk),
    .o_areset (areset)
  );

  rx_buffer_top dut_i (
    .i_clk                       (clk),
    .i_areset                    (areset),
    .i_dispatch_packet_available (pkt_avail),
    .o_dispatch_packet_read      (pkt_read),
    .i_dispatch_fifo_empty       (fifo_empty),
    .o_dispatch_fifo_rd_en       (fifo_rd_en),
    .i_dispatch_fifo_rd_data     (fifo_rd_data),
    .o_access_port_wait          (acc_wait),
    .i_access_port_addr          (acc_addr),
    .i_access_port_wordsize      (acc_size),
    .i_access_port_rd_en         (acc_rd_en),
    .o_access_port_rd_dv         (acc_rd_dv),
    .o_access_port_rd_data       (acc_rd_data)
  );

  assign fifo_empty   = ({1'b0, rd_ptr} >= fifo_len);
  // Head word on the data bus and zero while empty
  assign fifo_rd_data = fifo_empty ? '0 : fifo_mem[rd_ptr];

  // Pop request is sampled mid-cycle and the head moves after the edge
  always begin
    @(negedge clk);
    pop_now = fifo_rd_en;
    @(posedge clk);
    #2;
    if (pop_now) begin
      rd_ptr = rd_ptr + 6'd1;
      pop_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > 100 + PKT_WORDS + 8 * t_name.size()) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // Next drive point where the dispatcher drops the packet on packet_read
  task automatic step();
    @(posedge clk);
    #2;
    if (pkt_read) begin
      pr_count++;
      pkt_avail = 1'b0;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic add_test(input string name, input int addr, input int size,
                          input int mode);
    t_name.push_back(name);
    t_addr.push_back(13'(addr));
    t_size.push_back(3'(size));
    t_mode.push_back(mode);
  endtask

  task automatic push_packet(input int n_words);
    logic [63:0] word;
    for (int k = 0; k < n_words; k++) begin
      word = {$random(seed), $random(seed)};
      fifo_mem[fifo_len[5:0] + 6'(k)] = word;
      ref_words[10'(k)] = word;
    end
    fifo_len = fifo_len + 7'(n_words);
  endtask

  // Big-endian byte stream right-justified with zero fill
  function automatic logic [63:0] expected_read(input logic [12:0] addr,
                                                input logic [2:0] size);
    logic [63:0] result;
    logic [63:0] w;
    logic [12:0] pos;
    int          nbytes;
    result = '0;
    nbytes = 1 << size;
    for (int n = 0; n < 8; n++) begin
      if (n < nbytes) begin
        pos    = addr + 13'(n);
        w      = ref_words[pos[12:3]] << {pos[2:0], 3'b000};
        result = {result[55:0], w[63:56]};
      end
    end
    return result;
  endfunction

  task automatic run_load();
    int pops_before;
    int pr_before;
    int n;
    pops_before = pop_count;
    pr_before   = pr_count;
    push_packet(PKT_WORDS);
    pkt_avail = 1'b1;
    n = 0;
    while (pr_count == pr_before && n < PKT_WORDS + 20) begin
      step();
      n++;
    end
    if (pr_count == pr_before) begin
      $display("load: packet_read never pulsed");
      err_count++;
    end
    repeat (3) step();
    check_value("load packet_read pulses", 64'd1, 64'(pr_count - pr_before));
    check_value("load pops", 64'(PKT_WORDS), 64'(pop_count - pops_before));
    check_value("load fifo level", 64'(fifo_len), 64'(rd_ptr));
  endtask

  task automatic run_read(input int idx);
    string       name;
    logic [63:0] exp_data;
    logic [12:0] last_byte;
    int          exp_lat;
    int          nbytes;
    int          lat;
    int          n;
    int          pr_before;
    logic        accepted;
    logic        got;
    name      = t_name[idx];
    pr_before = pr_count;
    if (t_mode[idx] == MODE_NEWPKT) begin
      push_packet(SECOND_WORDS);
      pkt_avail = 1'b1;
    end
    acc_addr  = t_addr[idx];
    acc_size  = t_size[idx];
    acc_rd_en = 1'b1;
    accepted  = 1'b0;
    n = 0;
    while (!accepted && n < ACCEPT_LIMIT) begin
      step();
      n++;
      accepted = acc_wait;
    end
    acc_rd_en = 1'b0;
    if (!accepted) begin
      $display("%s: request was never accepted", name);
      err_count++;
    end else begin
      if (t_mode[idx] == MODE_NEWPKT && pr_count != pr_before + 1) begin
        $display("%s: read accepted before the load finished", name);
        err_count++;
      end
      nbytes    = 1 << t_size[idx];
      last_byte = t_addr[idx] + 13'(nbytes - 1);
      // A read whose last byte sits in the next word takes one more cycle
      exp_lat   = (last_byte[12:3] != t_addr[idx][12:3]) ? 3 : 2;
      lat = 0;
      got = 1'b0;
      while (!got && lat < DV_LIMIT) begin
        step();
        lat++;
        got = acc_rd_dv;
      end
      if (!got) begin
        $display("%s: no rd_dv after the request was accepted", name);
        err_count++;
      end else begin
        exp_data = expected_read(t_addr[idx], t_size[idx]);
        check_value({name, " latency"}, 64'(exp_lat), 64'(lat));
        check_value(name, exp_data, acc_rd_data);
      end
    end
  endtask

  task automatic run_invalid(input int idx);
    logic bad;
    acc_addr  = t_addr[idx];
    acc_size  = t_size[idx];
    acc_rd_en = 1'b1;
    bad = 1'b0;
    for (int c = 0; c < BAD_CYCLES; c++) begin
      step();
      if (acc_wait || acc_rd_dv) begin
        bad = 1'b1;
      end
    end
    acc_rd_en = 1'b0;
    if (bad) begin
      $display("%s: invalid wordsize got a response", t_name[idx]);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("test %-18s ok", name);
      n_pass++;
    end else begin
      $display("test %-18s failed", name);
      n_fail++;
    end
  endtask

  // --------------------------------------------------
  // Stimulus table and main sequence
  // --------------------------------------------------

  initial begin
    int errs_before;
    add_test("rd8_aligned", 24, 0, MODE_READ);
    add_test("rd16_aligned", 32, 1, MODE_READ);
    add_test("rd32_aligned", 40, 2, MODE_READ);
    add_test("rd64_aligned", 48, 3, MODE_READ);
    add_test("rd8_off7", 23, 0, MODE_READ);
    add_test("rd16_off6", 62, 1, MODE_READ);
    add_test("rd32_off4", 76, 2, MODE_READ);
    add_test("rd16_off7_span", 87, 1, MODE_READ);
    add_test("rd32_off5_span", 93, 2, MODE_READ);
    add_test("rd32_off7_span", 103, 2, MODE_READ);
    add_test("rd64_off1_span", 105, 3, MODE_READ);
    add_test("rd64_off4_span", 116, 3, MODE_READ);
    add_test("rd64_off7_last", 311, 3, MODE_READ);
    add_test("bad_size4", 8, 4, MODE_INVALID);
    add_test("rd8_after_bad", 9, 0, MODE_READ);
    add_test("bad_size7", 16, 7, MODE_INVALID);
    add_test("rd64_off3_span", 163, 3, MODE_READ);
    add_test("newpkt_rd32_off6", 22, 2, MODE_NEWPKT);
    add_test("newpkt_rd64_w7", 56, 3, MODE_READ);
    add_test("old_rd64_w20", 160, 3, MODE_READ);

    wait (areset == 1'b0);
    step();

    errs_before = err_count;
    run_load();
    report_test("load", errs_before);

    for (int i = 0; i < t_name.size(); i++) begin
      errs_before = err_count;
      if (t_mode[i] == MODE_INVALID) begin
        run_invalid(i);
      end else begin
        run_read(i);
      end
      report_test(t_name[i], errs_before);
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* rx_buffer.f */
rtl/rx_mem_pkg.sv
rtl/rx_access_pkg.sv
rtl/rx_read_if.sv
rtl/rx_buffer_ram.sv
rtl/rx_fifo_loader.sv
rtl/rx_buffer_ctrl.sv
rtl/rx_read_extract.sv
rtl/rx_buffer_top.sv
tb/tb_clkgen.sv
tb/rx_buffer_assert.sv
tb/rx_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; the result comes from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rx_buffer_tb \
  -f rx_buffer.f -o rx_buffer_sim || { echo "build failed"; exit 1; }

./obj_dir/rx_buffer_sim | tee /dev/stderr | grep -qx "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }
